/* design/mul_data_pkg.sv */
package mul_data_pkg;

    // operand and product widths
    localparam int OPERAND_W = 32;
    localparam int HALF_W    = OPERAND_W / 2;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // middle term of the four-step sum, product without the low half-word
    localparam int ACC_W     = OPERAND_W + HALF_W;

    // full 32-bit operand or magnitude
    typedef logic [OPERAND_W-1:0] operand_t;

    // one half-word fed to the 16x16 array
    typedef logic [HALF_W-1:0] half_t;

    // result of one 16x16 array pass
    typedef logic [2*HALF_W-1:0] half_prod_t;

    // accumulator for the upper 48 bits
    typedef logic [ACC_W-1:0] acc_t;

    // complete 64-bit product
    typedef logic [PRODUCT_W-1:0] product_t;

endpackage

/* design/mul_ctrl_pkg.sv */
package mul_ctrl_pkg;

    // one array pass per half-word pair
    localparam int NUM_STEPS = 4;

    // sequencer steps, named after the half-words of op_a and op_b
    typedef enum logic [$clog2(NUM_STEPS)-1:0] {
        STEP_LL,
        STEP_HL,
        STEP_LH,
        STEP_HH
    } seq_state_t;

    // operand interpretation
    typedef enum logic [1:0] {
        MODE_UNSIGNED,
        MODE_MULHSU,
        MODE_SIGNED
    } mul_mode_t;

endpackage

/* design/ripple_carry_adder.sv */
`timescale 1ns/1ps

module ripple_carry_adder
    import mul_data_pkg::*;
#(
    parameter int WIDTH = OPERAND_W
) (
    input  logic [WIDTH-1:0] a_i,
    input  logic [WIDTH-1:0] b_i,
    output logic [WIDTH-1:0] sum_o
);

    // carry into each bit position, bit 0 has no carry-in
    logic [WIDTH-1:0] carry;

    assign carry[0] = 1'b0;

    for (genvar i = 0; i < WIDTH; i++) begin : g_fa
        assign sum_o[i] = a_i[i] ^ b_i[i] ^ carry[i];

        // carry out of the top bit is dropped
        if (i < WIDTH - 1) begin : g_carry
            assign carry[i+1] = (a_i[i] & b_i[i]) | ((a_i[i] ^ b_i[i]) & carry[i]);
        end
    end

endmodule

/* design/vedic_mult.sv */
`timescale 1ns/1ps

module vedic_mult
    import mul_data_pkg::*;
#(
    parameter int WIDTH = HALF_W
) (
    input  logic [WIDTH-1:0]   a_i,
    input  logic [WIDTH-1:0]   b_i,
    output logic [2*WIDTH-1:0] prod_o
);

    if (WIDTH == 2) begin : g_cell
        logic pp_hl;
        logic pp_lh;
        logic pp_hh;
        logic c_mid;

        // bit products
        assign prod_o[0] = a_i[0] & b_i[0];
        assign pp_hl     = a_i[1] & b_i[0];
        assign pp_lh     = a_i[0] & b_i[1];
        assign pp_hh     = a_i[1] & b_i[1];

        // first half adder, cross terms
        assign prod_o[1] = pp_hl ^ pp_lh;
        assign c_mid     = pp_hl & pp_lh;

        // second half adder, top term plus carry
        assign prod_o[2] = pp_hh ^ c_mid;
        assign prod_o[3] = pp_hh & c_mid;
    end else begin : g_split
        localparam int H     = WIDTH / 2;
        // sum width, product above the low quarter
        localparam int SUM_W = WIDTH + H;

        logic [WIDTH-1:0] q_ll;
        logic [WIDTH-1:0] q_hl;
        logic [WIDTH-1:0] q_lh;
        logic [WIDTH-1:0] q_hh;
        logic [SUM_W-1:0] s_low;
        logic [SUM_W-1:0] s_high;
        logic [SUM_W-1:0] s_all;

        // four half-width cross products
        vedic_mult #(.WIDTH(H)) u_ll (.a_i(a_i[H-1:0]),     .b_i(b_i[H-1:0]),     .prod_o(q_ll));
        vedic_mult #(.WIDTH(H)) u_hl (.a_i(a_i[WIDTH-1:H]), .b_i(b_i[H-1:0]),     .prod_o(q_hl));
        vedic_mult #(.WIDTH(H)) u_lh (.a_i(a_i[H-1:0]),     .b_i(b_i[WIDTH-1:H]), .prod_o(q_lh));
        vedic_mult #(.WIDTH(H)) u_hh (.a_i(a_i[WIDTH-1:H]), .b_i(b_i[WIDTH-1:H]), .prod_o(q_hh));

        // high-low term plus the spill of the low-low product
        ripple_carry_adder #(.WIDTH(SUM_W)) u_add_low (
            .a_i   ({{H{1'b0}}, q_hl}),
            .b_i   ({{WIDTH{1'b0}}, q_ll[WIDTH-1:H]}),
            .sum_o (s_low)
        );

        // low-high term plus the high-high product shifted up by H
        ripple_carry_adder #(.WIDTH(SUM_W)) u_add_high (
            .a_i   ({{H{1'b0}}, q_lh}),
            .b_i   ({q_hh, {H{1'b0}}}),
            .sum_o (s_high)
        );

        ripple_carry_adder #(.WIDTH(SUM_W)) u_add_all (
            .a_i   (s_low),
            .b_i   (s_high),
            .sum_o (s_all)
        );

        // lowest quarter is never touched by the adders
        assign prod_o = {s_all, q_ll[H-1:0]};
    end

endmodule

/* design/operand_sign_unit.sv */
`timescale 1ns/1ps

module operand_sign_unit
    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  mul_mode_t mode_i,
    input  logic      start_i,
    input  operand_t  op_a_i,
    input  operand_t  op_b_i,
    input  product_t  mag_prod_i,
    input  logic      ready_i,
    output operand_t  mag_a_o,
    output operand_t  mag_b_o,
    output product_t  product_o
);

    logic a_neg;
    logic b_neg;
    logic negate_d;
    logic negate_q;

    // op_a is signed in both mulhsu and signed mode
    assign a_neg = op_a_i[OPERAND_W-1] && (mode_i != MODE_UNSIGNED);

    // op_b only in signed mode
    assign b_neg = op_b_i[OPERAND_W-1] && (mode_i == MODE_SIGNED);

    // two's-complement magnitudes, 0x80000000 maps onto itself as unsigned
    assign mag_a_o = a_neg ? (~op_a_i + operand_t'(1)) : op_a_i;
    assign mag_b_o = b_neg ? (~op_b_i + operand_t'(1)) : op_b_i;

    // negative result when exactly one operand was negative
    assign negate_d = a_neg ^ b_neg;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            negate_q <= 1'b0;
        end else if (start_i) begin
            negate_q <= negate_d;
        end
    end

    // result only during the ready cycle, zero otherwise
    always_comb begin
        if (!ready_i) begin
            product_o = '0;
        end else if (negate_q) begin
            product_o = ~mag_prod_i + product_t'(1);
        end else begin
            product_o = mag_prod_i;
        end
    end

endmodule

/* design/partial_product_seq.sv */
`timescale 1ns/1ps

module partial_product_seq
    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       active_i,
    input  operand_t   mag_a_i,
    input  operand_t   mag_b_i,
    input  half_prod_t vm_prod_i,
    output half_t      vm_a_o,
    output half_t      vm_b_o,
    output logic       start_o,
    output logic       ready_o,
    output product_t   mag_prod_o
);

    seq_state_t state_q;
    seq_state_t state_d;

    logic a_hi_sel;
    logic b_hi_sel;

    // partial products kept from earlier steps
    half_prod_t ll_q;
    half_prod_t hl_q;
    acc_t       lh_q;

    half_prod_t mid_sum;
    acc_t       top_sum;
    acc_t       acc_sum;

    // step order LL, HL, LH, HH
    always_comb begin
        case (state_q)
            STEP_LL: state_d = STEP_HL;
            STEP_HL: state_d = STEP_LH;
            STEP_LH: state_d = STEP_HH;
            default: state_d = STEP_LL;
        endcase
    end

    // hold the step while the block is idle
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= STEP_LL;
        end else if (active_i) begin
            state_q <= state_d;
        end
    end

    // half-word selection for the shared array
    assign a_hi_sel = (state_q == STEP_HL) || (state_q == STEP_HH);
    assign b_hi_sel = (state_q == STEP_LH) || (state_q == STEP_HH);

    assign vm_a_o = a_hi_sel ? mag_a_i[OPERAND_W-1:HALF_W] : mag_a_i[HALF_W-1:0];
    assign vm_b_o = b_hi_sel ? mag_b_i[OPERAND_W-1:HALF_W] : mag_b_i[HALF_W-1:0];

    // partial product capture, one register per step
    always_ff @(posedge clk_i) begin
        if (active_i) begin
            case (state_q)
                STEP_LL: ll_q <= vm_prod_i;
                STEP_HL: hl_q <= vm_prod_i;
                STEP_LH: lh_q <= {{HALF_W{1'b0}}, vm_prod_i};
                default: ;
            endcase
        end
    end

    // high-low plus the upper half of low-low
    ripple_carry_adder #(.WIDTH(OPERAND_W)) u_add_mid (
        .a_i   (hl_q),
        .b_i   ({{HALF_W{1'b0}}, ll_q[OPERAND_W-1:HALF_W]}),
        .sum_o (mid_sum)
    );

    // low-high plus the live high-high product, aligned one half-word up
    ripple_carry_adder #(.WIDTH(ACC_W)) u_add_top (
        .a_i   (lh_q),
        .b_i   ({vm_prod_i, {HALF_W{1'b0}}}),
        .sum_o (top_sum)
    );

    ripple_carry_adder #(.WIDTH(ACC_W)) u_add_acc (
        .a_i   ({{HALF_W{1'b0}}, mid_sum}),
        .b_i   (top_sum),
        .sum_o (acc_sum)
    );

    // valid only in STEP_HH, the sign unit masks it otherwise
    assign mag_prod_o = {acc_sum, ll_q[HALF_W-1:0]};

    // new operation begins, sign unit latches the negate flag
    assign start_o = active_i && (state_q == STEP_LL);

    assign ready_o = active_i && (state_q == STEP_HH);

endmodule

/* design/vedic_multiplier_top.sv */
`timescale 1ns/1ps

module vedic_multiplier_top
    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     active_i,
    input  logic     unsigned_i,
    input  logic     mulhsu_i,
    input  operand_t op_a_i,
    input  operand_t op_b_i,
    output product_t product_o,
    output logic     ready_o
);

    mul_mode_t  mode;
    operand_t   mag_a;
    operand_t   mag_b;
    product_t   mag_prod;
    half_t      vm_a;
    half_t      vm_b;
    half_prod_t vm_prod;
    logic       start;

    // unsigned wins over mulhsu, signed when neither is set
    assign mode = unsigned_i ? MODE_UNSIGNED : (mulhsu_i ? MODE_MULHSU : MODE_SIGNED);

    operand_sign_unit u_sign (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mode_i     (mode),
        .start_i    (start),
        .op_a_i     (op_a_i),
        .op_b_i     (op_b_i),
        .mag_prod_i (mag_prod),
        .ready_i    (ready_o),
        .mag_a_o    (mag_a),
        .mag_b_o    (mag_b),
        .product_o  (product_o)
    );

    partial_product_seq u_seq (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .active_i   (active_i),
        .mag_a_i    (mag_a),
        .mag_b_i    (mag_b),
        .vm_prod_i  (vm_prod),
        .vm_a_o     (vm_a),
        .vm_b_o     (vm_b),
        .start_o    (start),
        .ready_o    (ready_o),
        .mag_prod_o (mag_prod)
    );

    // shared 16x16 array, reused on every step
    vedic_mult #(.WIDTH(HALF_W)) u_vedic (
        .a_i    (vm_a),
        .b_i    (vm_b),
        .prod_o (vm_prod)
    );

endmodule

/* tb/tb_vedic_multiplier.sv */
`timescale 1ns/1ps

module tb_vedic_multiplier;

    localparam int NUM_RANDOM = 16;
    localparam int NUM_STALL  = 2;
    localparam int MARGIN     = 50;

    logic        clk_i;
    logic        rst_i;
    logic        active_i;
    logic        unsigned_i;
    logic        mulhsu_i;
    logic [31:0] op_a_i;
    logic [31:0] op_b_i;
    logic [63:0] product_o;
    logic        ready_o;

    // pattern file columns
    logic [1:0]  pat_mode[$];
    logic [31:0] pat_a[$];
    logic [31:0] pat_b[$];
    logic [63:0] pat_exp[$];

    int          error_count = 0;
    int          test_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] rand_state  = 32'h1b2f1001;

    vedic_multiplier_top dut0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .active_i   (active_i),
        .unsigned_i (unsigned_i),
        .mulhsu_i   (mulhsu_i),
        .op_a_i     (op_a_i),
        .op_b_i     (op_b_i),
        .product_o  (product_o),
        .ready_o    (ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // cycle watchdog with the limit set after loading
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // mode bit 0 is unsigned_i and bit 1 is mulhsu_i
    function automatic logic [63:0] ref_product(input logic [1:0] m, input logic [31:0] a,
                                                input logic [31:0] b);
        logic [63:0] xa;
        logic [63:0] xb;
        if (m[0]) begin
            xa = {32'b0, a};
            xb = {32'b0, b};
        end else if (m[1]) begin
            xa = {{32{a[31]}}, a};
            xb = {32'b0, b};
        end else begin
            xa = {{32{a[31]}}, a};
            xb = {{32{b[31]}}, b};
        end
        // low 64 bits of the extended product are exact
        return xa * xb;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            fail_count++;
            $display("test %0d %s: FAILED", test_count, name);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        int          code;
        string       line;
        logic [1:0]  m;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] e;
        fd = $fopen("tb/mul_patterns.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open tb/mul_patterns.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h", m, a, b, e);
            if (n == 4) begin
                pat_mode.push_back(m);
                pat_a.push_back(a);
                pat_b.push_back(b);
                pat_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle(input int cycles);
        int errors_before;
        errors_before = error_count;
        active_i = 1'b0;
        repeat (cycles) begin
            @(negedge clk_i);
            check_value("ready_o", 64'(ready_o), 64'd0);
            check_value("product_o", product_o, 64'd0);
        end
        report_test("idle after reset", errors_before);
    endtask

    // starts on a falling edge with the sequencer in its first step
    task automatic run_op(input logic [1:0] m, input logic [31:0] a, input logic [31:0] b,
                          input logic [63:0] exp, input string name, input int errors_before);
        unsigned_i = m[0];
        mulhsu_i   = m[1];
        op_a_i     = a;
        op_b_i     = b;
        active_i   = 1'b1;
        // samples land mid-cycle and the third one falls in the fourth cycle
        for (int step = 1; step <= 4; step++) begin
            @(negedge clk_i);
            check_value("ready_o", 64'(ready_o), (step == 3) ? 64'd1 : 64'd0);
            check_value("product_o", product_o, (step == 3) ? exp : 64'd0);
        end
        report_test(name, errors_before);
    endtask

    // active_i drops for gap cycles after steps_before of the four steps
    task automatic run_stalled_op(input int idx, input int steps_before, input int gap);
        int errors_before;
        errors_before = error_count;
        unsigned_i    = pat_mode[idx][0];
        mulhsu_i      = pat_mode[idx][1];
        op_a_i        = pat_a[idx];
        op_b_i        = pat_b[idx];
        active_i      = 1'b1;
        repeat (steps_before) begin
            @(negedge clk_i);
            check_value("ready_o", 64'(ready_o), 64'd0);
            check_value("product_o", product_o, 64'd0);
        end
        active_i = 1'b0;
        repeat (gap) begin
            @(negedge clk_i);
            check_value("ready_o", 64'(ready_o), 64'd0);
            check_value("product_o", product_o, 64'd0);
        end
        active_i = 1'b1;
        for (int step = steps_before + 1; step <= 4; step++) begin
            @(negedge clk_i);
            check_value("ready_o", 64'(ready_o), (step == 3) ? 64'd1 : 64'd0);
            check_value("product_o", product_o, (step == 3) ? pat_exp[idx] : 64'd0);
        end
        report_test($sformatf("stall after %0d steps", steps_before), errors_before);
    endtask

    initial begin
        int          errors_before;
        logic [1:0]  m;
        logic [31:0] a;
        logic [31:0] b;
        rst_i      = 1'b0;
        active_i   = 1'b0;
        unsigned_i = 1'b0;
        mulhsu_i   = 1'b0;
        op_a_i     = '0;
        op_b_i     = '0;

        load_patterns();
        cycle_limit = (pat_a.size() + NUM_RANDOM + NUM_STALL) * 4 + MARGIN;
        if (pat_a.size() <= 20) begin
            $display("Error: pattern file holds too few tests for the stall checks");
            error_count++;
        end

        repeat (10) @(negedge clk_i);
        rst_i = 1'b1;

        check_idle(8);

        // patterns back to back with active_i held high
        for (int i = 0; i < pat_a.size(); i++) begin
            errors_before = error_count;
            check_value("pattern file product", pat_exp[i],
                        ref_product(pat_mode[i], pat_a[i], pat_b[i]));
            run_op(pat_mode[i], pat_a[i], pat_b[i], pat_exp[i],
                   $sformatf("pattern %0d", i), errors_before);
        end
        active_i = 1'b0;
        @(negedge clk_i);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_state = lcg_next(rand_state);
            m          = rand_state[17:16];
            rand_state = lcg_next(rand_state);
            a          = rand_state;
            rand_state = lcg_next(rand_state);
            b          = rand_state;
            run_op(m, a, b, ref_product(m, a, b), $sformatf("random %0d", i), error_count);
        end
        active_i = 1'b0;
        @(negedge clk_i);

        // negative signed results exercise the held sign flag
        if (pat_a.size() > 20) begin
            run_stalled_op(14, 1, 3);
            run_stalled_op(20, 2, 3);
        end
        active_i = 1'b0;
        @(negedge clk_i);

        $display("tests run %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tb/mul_patterns.txt */
# columns: mode op_a op_b expected_product, all hex
# mode: 1 unsigned, 2 mulhsu, 0 signed, 3 both set (unsigned wins)
1 00000000 00000000 0000000000000000
1 ffffffff ffffffff fffffffe00000001
1 00000003 00000005 000000000000000f
1 12345678 00000010 0000000123456780
1 80000000 00000002 0000000100000000
1 0000ffff 0000ffff 00000000fffe0001
1 00010000 00010000 0000000100000000
1 ffffffff 00000002 00000001fffffffe
3 ffffffff 00000001 00000000ffffffff
2 ffffffff 80000001 ffffffff7fffffff
2 fffffffe c0000000 fffffffe80000000
2 00000003 ffffffff 00000002fffffffd
2 80000000 ffffffff 8000000080000000
0 00000007 00000006 000000000000002a
0 fffffff9 00000006 ffffffffffffffd6
0 00000007 fffffffa ffffffffffffffd6
0 fffffff9 fffffffa 000000000000002a
0 80000000 80000000 4000000000000000
0 ffffffff ffffffff 0000000000000001
0 7fffffff 7fffffff 3fffffff00000001
0 80000000 7fffffff c000000080000000
0 12345678 ffffffff ffffffffedcba988
1 00010001 00010001 0000000100020001
2 00000001 80000000 0000000080000000
0 00000000 80000000 0000000000000000
1 0000ffff 00010000 00000000ffff0000
2 80000000 80000000 c000000000000000
3 80000000 80000000 4000000000000000
0 0000ffff ffff0000 ffffffff00010000
1 deadbeef 00000001 00000000deadbeef

/* filelist.f */
design/mul_data_pkg.sv
design/mul_ctrl_pkg.sv
design/ripple_carry_adder.sv
design/vedic_mult.sv
design/operand_sign_unit.sv
design/partial_product_seq.sv
design/vedic_multiplier_top.sv
tb/tb_vedic_multiplier.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_vedic_multiplier
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
